// File: source/rv_decode_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions for the RV32I decode stage
// Widths, field types, opcode and func constants, control enums
//////////////////////////////////////////////////////////////////////
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       instr_t;
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;

    //////////////////////////////////////////////////////////////////////
    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    //////////////////////////////////////////////////////////////////////
    // func3 / func7 / func12 codes
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // SRL and SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_B    = 3'b000;  // Access widths, loads and stores
    localparam funct3_t F3_H    = 3'b001;
    localparam funct3_t F3_W    = 3'b010;
    localparam funct3_t F3_BU   = 3'b100;
    localparam funct3_t F3_HU   = 3'b101;

    localparam funct3_t F3_JALR = 3'b000;
    localparam funct3_t F3_PRIV = 3'b000;  // Non-CSR SYSTEM

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;
    localparam logic [11:0] F12_WFI    = 12'h105;

    //////////////////////////////////////////////////////////////////////
    // Control encodings
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_SLL = 4'd2, ALU_SRL = 4'd3,
        ALU_SRA = 4'd4, ALU_XOR = 4'd5, ALU_OR  = 4'd6, ALU_AND = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_UN = 3'd0, CMP_EQ = 3'd1, CMP_NQ  = 3'd2, CMP_LT = 3'd3,
        CMP_GE = 3'd4, CMP_LTU = 3'd5, CMP_GEU = 3'd6
    } cmp_func_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0, IMM_S = 3'd1, IMM_B = 3'd2, IMM_U = 3'd3, IMM_J = 3'd4
    } imm_fmt_e;

    typedef enum logic [2:0] {
        DIN_IMM = 3'd0, DIN_PC_NEXT = 3'd1, DIN_ALU = 3'd2, DIN_CMP = 3'd3,
        DIN_MEM = 3'd4
    } rf_din_sel_e;

endpackage

// File: source/decode_ctrl_if.sv
//////////////////////////////////////////////////////////////////////
// Decoder control word bundle
// Driven by the control decoder, read by imm gen and the stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface decode_ctrl_if import rv_decode_pkg::*; ();

    logic        illegal;
    logic        jump_en;
    logic        wfi;
    cmp_func_e   cmp_type;
    logic        rf_we;
    rf_din_sel_e rf_din_sel;
    logic        a_op_sel;      // 1 selects PC
    logic        b_op_sel;      // 1 selects immediate
    logic        cmp_b_op_sel;  // 1 selects immediate
    alu_op_e     alu_op;
    logic        mem_req;
    logic        mem_we;
    imm_fmt_e    imm_fmt;

    modport dec (
        output illegal, jump_en, wfi, cmp_type, rf_we, rf_din_sel,
               a_op_sel, b_op_sel, cmp_b_op_sel, alu_op, mem_req, mem_we, imm_fmt
    );

    modport imm (
        input imm_fmt
    );

    modport stage (
        input illegal, jump_en, wfi, cmp_type, rf_we, rf_din_sel,
              a_op_sel, b_op_sel, cmp_b_op_sel, alu_op, mem_req, mem_we
    );

endinterface

// File: source/rv_ctrl_decode.sv
//////////////////////////////////////////////////////////////////////
// RV32I control decoder
// opcode/func3/func7 match into control word and immediate format
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_ctrl_decode
    import rv_decode_pkg::*;
(
    input  instr_t     instr_i,
    decode_ctrl_if.dec ctrl
);

    logic [6:0]  opcode;
    funct3_t     func3;
    logic [6:0]  func7;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    logic [11:0] funct12;
    logic        alt_f7;
    logic        op_f7_ok;
    logic        imm_f7_ok;
    cmp_func_e   br_cmp;

    function automatic cmp_func_e branch_cmp(input funct3_t f3);
        cmp_func_e c;
        case (f3)
            F3_BEQ:  c = CMP_EQ;
            F3_BNE:  c = CMP_NQ;
            F3_BLT:  c = CMP_LT;
            F3_BGE:  c = CMP_GE;
            F3_BLTU: c = CMP_LTU;
            F3_BGEU: c = CMP_GEU;
            default: c = CMP_UN;  // 010/011 unused
        endcase
        return c;
    endfunction

    function automatic alu_op_e alu_op_of(input funct3_t f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;  // SLT/SLTU go through the comparator
        endcase
        return op;
    endfunction

    assign opcode  = instr_i[6:0];
    assign func3   = instr_i[14:12];
    assign func7   = instr_i[31:25];
    assign rd      = instr_i[11:7];
    assign rs1     = instr_i[19:15];
    assign funct12 = instr_i[31:20];

    assign alt_f7    = (func7 == F7_ALT);
    assign op_f7_ok  = (func7 == F7_BASE) || (alt_f7 && (func3 == F3_ADD || func3 == F3_SR));
    assign imm_f7_ok = (func3 == F3_SLL) ? (func7 == F7_BASE) :
                       (func3 == F3_SR)  ? (func7 == F7_BASE || alt_f7) : 1'b1;
    assign br_cmp    = branch_cmp(func3);

    always_comb
    begin
        ctrl.illegal      = 1'b0;
        ctrl.jump_en      = 1'b0;
        ctrl.wfi          = 1'b0;
        ctrl.cmp_type     = CMP_UN;
        ctrl.rf_we        = 1'b0;
        ctrl.rf_din_sel   = DIN_IMM;
        ctrl.a_op_sel     = 1'b0;
        ctrl.b_op_sel     = 1'b0;
        ctrl.cmp_b_op_sel = 1'b0;
        ctrl.alu_op       = ALU_ADD;
        ctrl.mem_req      = 1'b0;
        ctrl.mem_we       = 1'b0;
        ctrl.imm_fmt      = IMM_U;

        case (opcode)
            OPC_LUI:
            begin
                ctrl.rf_we = 1'b1;
            end

            OPC_AUIPC:
            begin
                ctrl.rf_we      = 1'b1;
                ctrl.rf_din_sel = DIN_ALU;
                ctrl.a_op_sel   = 1'b1;  // PC + imm
                ctrl.b_op_sel   = 1'b1;
            end

            OPC_JAL:
            begin
                ctrl.jump_en    = 1'b1;
                ctrl.rf_we      = 1'b1;
                ctrl.rf_din_sel = DIN_PC_NEXT;  // Link address
                ctrl.a_op_sel   = 1'b1;
                ctrl.b_op_sel   = 1'b1;
                ctrl.imm_fmt    = IMM_J;
            end

            OPC_JALR:
            begin
                if (func3 != F3_JALR)
                    ctrl.illegal = 1'b1;
                else
                begin
                    ctrl.jump_en    = 1'b1;
                    ctrl.rf_we      = 1'b1;
                    ctrl.rf_din_sel = DIN_PC_NEXT;
                    ctrl.b_op_sel   = 1'b1;  // rs1 + imm
                    ctrl.imm_fmt    = IMM_I;
                end
            end

            OPC_BRANCH:
            begin
                if (br_cmp == CMP_UN)
                    ctrl.illegal = 1'b1;
                else
                begin
                    ctrl.jump_en  = 1'b1;
                    ctrl.cmp_type = br_cmp;
                    ctrl.a_op_sel = 1'b1;  // Target PC + imm
                    ctrl.b_op_sel = 1'b1;
                    ctrl.imm_fmt  = IMM_B;
                end
            end

            OPC_LOAD:
            begin
                ctrl.illegal    = !(func3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
                ctrl.rf_we      = 1'b1;
                ctrl.rf_din_sel = DIN_MEM;
                ctrl.b_op_sel   = 1'b1;  // Address rs1 + imm
                ctrl.mem_req    = 1'b1;
                ctrl.imm_fmt    = IMM_I;
            end

            OPC_STORE:
            begin
                ctrl.illegal  = !(func3 inside {F3_B, F3_H, F3_W});
                ctrl.b_op_sel = 1'b1;
                ctrl.mem_req  = 1'b1;
                ctrl.mem_we   = 1'b1;
                ctrl.imm_fmt  = IMM_S;
            end

            OPC_OP_IMM:
            begin
                if (!imm_f7_ok)
                    ctrl.illegal = 1'b1;
                else
                begin
                    ctrl.rf_we   = 1'b1;
                    ctrl.imm_fmt = IMM_I;
                    if (func3 == F3_SLT || func3 == F3_SLTU)
                    begin
                        ctrl.rf_din_sel   = DIN_CMP;
                        ctrl.cmp_b_op_sel = 1'b1;
                        ctrl.cmp_type     = (func3 == F3_SLT) ? CMP_LT : CMP_LTU;
                    end
                    else
                    begin
                        ctrl.rf_din_sel = DIN_ALU;
                        ctrl.b_op_sel   = 1'b1;
                        ctrl.alu_op     = alu_op_of(func3, alt_f7 && func3 == F3_SR);
                    end
                end
            end

            OPC_OP:
            begin
                if (!op_f7_ok)
                    ctrl.illegal = 1'b1;  // Also catches MUL/DIV
                else
                begin
                    ctrl.rf_we = 1'b1;
                    if (func3 == F3_SLT || func3 == F3_SLTU)
                    begin
                        ctrl.rf_din_sel = DIN_CMP;
                        ctrl.cmp_type   = (func3 == F3_SLT) ? CMP_LT : CMP_LTU;
                    end
                    else
                    begin
                        ctrl.rf_din_sel = DIN_ALU;
                        ctrl.alu_op     = alu_op_of(func3, alt_f7);
                    end
                end
            end

            OPC_SYSTEM:
            begin
                if (func3 == F3_PRIV && rd == '0 && rs1 == '0)
                begin
                    case (funct12)
                        F12_WFI:
                        begin
                            // Runs as ADDI x0, x0, imm
                            ctrl.wfi        = 1'b1;
                            ctrl.rf_we      = 1'b1;
                            ctrl.rf_din_sel = DIN_ALU;
                            ctrl.b_op_sel   = 1'b1;
                            ctrl.imm_fmt    = IMM_I;
                        end
                        F12_ECALL, F12_EBREAK, F12_MRET:
                            ctrl.illegal = 1'b1;  // No trap support
                        default:
                            ctrl.illegal = 1'b1;
                    endcase
                end
                else
                    ctrl.illegal = 1'b1;  // CSR access
            end

            default:
                ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: source/rv_imm_gen.sv
//////////////////////////////////////////////////////////////////////
// Immediate generator
// Sign-extended I, S, B, U and J immediates
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  instr_t     instr_i,
    decode_ctrl_if.imm ctrl,
    output word_t      imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb
    begin
        case (ctrl.imm_fmt)
            IMM_I:
                imm_o = {{21{sign}}, instr_i[30:20]};
            IMM_S:
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            IMM_B:
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_U:
                imm_o = {instr_i[31:12], 12'b0};  // Upper 20 bits
            IMM_J:
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

// File: source/rv_decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Registered RV32I decode stage, top level
// Field slicing, control and immediate decode, output register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_decode_stage
    import rv_decode_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        instr_valid_i,
    input  instr_t      instr_i,

    output logic        valid_o,
    output logic        illegal_instr_o,
    output reg_addr_t   rd_sel_o,
    output reg_addr_t   rs1_sel_o,
    output reg_addr_t   rs2_sel_o,
    output word_t       imm_o,
    output logic        jump_en_o,
    output logic        wfi_o,
    output cmp_func_e   comparison_type_o,
    output logic        rf_we_o,
    output rf_din_sel_e rf_din_sel_o,
    output logic        a_op_sel_o,
    output logic        b_op_sel_o,
    output logic        cmp_b_op_sel_o,
    output alu_op_e     alu_op_sel_o,
    output funct3_t     mem_access_width_o,
    output logic        mem_req_o,
    output logic        mem_we_o
);

    decode_ctrl_if ctrl_bus ();

    word_t imm;

    rv_ctrl_decode ctrl_decode_i (
        .instr_i (instr_i),
        .ctrl    (ctrl_bus.dec)
    );

    rv_imm_gen imm_gen_i (
        .instr_i (instr_i),
        .ctrl    (ctrl_bus.imm),
        .imm_o   (imm)
    );

    //////////////////////////////////////////////////////////////////////
    // Enables and valid
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            valid_o         <= 1'b0;
            illegal_instr_o <= 1'b0;
            jump_en_o       <= 1'b0;
            wfi_o           <= 1'b0;
            rf_we_o         <= 1'b0;
            mem_req_o       <= 1'b0;
            mem_we_o        <= 1'b0;
        end
        else
        begin
            valid_o <= instr_valid_i;  // One-cycle pulse per strobe
            if (instr_valid_i)
            begin
                illegal_instr_o <= ctrl_bus.illegal;
                jump_en_o       <= ctrl_bus.jump_en;
                wfi_o           <= ctrl_bus.wfi;
                rf_we_o         <= ctrl_bus.rf_we;
                mem_req_o       <= ctrl_bus.mem_req;
                mem_we_o        <= ctrl_bus.mem_we;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fields, immediate and selects
    always_ff @(posedge clk_i)
    begin
        if (instr_valid_i)
        begin
            rd_sel_o           <= instr_i[11:7];
            rs1_sel_o          <= instr_i[19:15];
            rs2_sel_o          <= instr_i[24:20];
            mem_access_width_o <= instr_i[14:12];  // func3
            imm_o              <= imm;
            comparison_type_o  <= ctrl_bus.cmp_type;
            rf_din_sel_o       <= ctrl_bus.rf_din_sel;
            a_op_sel_o         <= ctrl_bus.a_op_sel;
            b_op_sel_o         <= ctrl_bus.b_op_sel;
            cmp_b_op_sel_o     <= ctrl_bus.cmp_b_op_sel;
            alu_op_sel_o       <= ctrl_bus.alu_op;
        end
    end

endmodule

// File: sim/rv_decode_stage_chk.sv
//////////////////////////////////////////////////////////////////////
// Decode stage invariants, bound into the top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_decode_stage_chk (
    input logic clk_i,
    input logic reset_i,
    input logic instr_valid_i,
    input logic valid_o,
    input logic mem_we_o,
    input logic mem_req_o,
    input logic jump_en_o,
    input logic wfi_o,
    input logic rf_we_o
);

    // valid_o is the strobe delayed by one clock
    a_valid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
        !$past(reset_i) |-> valid_o == $past(instr_valid_i))
        else $error("valid_o does not follow instr_valid_i");

    a_we_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_we_o |-> mem_req_o)
        else $error("mem_we_o without mem_req_o");

    a_jump_no_mem: assert property (@(posedge clk_i) disable iff (reset_i)
        !(jump_en_o && mem_req_o))
        else $error("jump_en_o and mem_req_o both high");

    a_wfi_writes: assert property (@(posedge clk_i) disable iff (reset_i)
        wfi_o |-> rf_we_o)
        else $error("wfi_o without rf_we_o");

    a_reset_clear: assert property (@(posedge clk_i) $past(reset_i) |-> !valid_o)
        else $error("valid_o high right after reset");

endmodule

bind rv_decode_stage rv_decode_stage_chk chk_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .valid_o       (valid_o),
    .mem_we_o      (mem_we_o),
    .mem_req_o     (mem_req_o),
    .jump_en_o     (jump_en_o),
    .wfi_o         (wfi_o),
    .rf_we_o       (rf_we_o)
);

// File: sim/rv_decode_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the registered RV32I decode stage
// Clock, reset, golden-file stimulus, typed compares, watchdog
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_decode_stage_tb
    import rv_decode_pkg::*;
;

    localparam int MAX_VEC = 64;
    localparam int N_COL   = 18;

    logic        clk_i;
    logic        reset_i;
    logic        instr_valid_i;
    instr_t      instr_i;
    logic        valid_o;
    logic        illegal_instr_o;
    reg_addr_t   rd_sel_o;
    reg_addr_t   rs1_sel_o;
    reg_addr_t   rs2_sel_o;
    word_t       imm_o;
    logic        jump_en_o;
    logic        wfi_o;
    cmp_func_e   comparison_type_o;
    logic        rf_we_o;
    rf_din_sel_e rf_din_sel_o;
    logic        a_op_sel_o;
    logic        b_op_sel_o;
    logic        cmp_b_op_sel_o;
    alu_op_e     alu_op_sel_o;
    funct3_t     mem_access_width_o;
    logic        mem_req_o;
    logic        mem_we_o;

    // Columns: instr rd rs1 rs2 width imm ill jmp wfi cmp we din a b cb alu mreq mwe
    logic [31:0] golden [0:MAX_VEC-1][0:N_COL-1];
    int          n_vec;
    int          errors;
    logic        loaded;

    rv_decode_stage rv_decode_stage_i (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Typed compares
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[FAIL] %0t: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            report_mismatch(name, {27'b0, exp}, {27'b0, act});
    endtask

    task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
        if (act !== exp)
            report_mismatch(name, {28'b0, exp}, {28'b0, act});
    endtask

    task automatic check_cmp_func(input string name, input cmp_func_e exp, input cmp_func_e act);
        if (act !== exp)
            report_mismatch(name, {29'b0, exp}, {29'b0, act});
    endtask

    task automatic check_din_sel(input string name, input rf_din_sel_e exp,
                                 input rf_din_sel_e act);
        if (act !== exp)
            report_mismatch(name, {29'b0, exp}, {29'b0, act});
    endtask

    task automatic check_funct3(input string name, input funct3_t exp, input funct3_t act);
        if (act !== exp)
            report_mismatch(name, {29'b0, exp}, {29'b0, act});
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, {31'b0, exp}, {31'b0, act});
    endtask

    task automatic check_reset_state();
        check_bit("valid_o", 1'b0, valid_o);
        check_bit("illegal_instr_o", 1'b0, illegal_instr_o);
        check_bit("jump_en_o", 1'b0, jump_en_o);
        check_bit("wfi_o", 1'b0, wfi_o);
        check_bit("rf_we_o", 1'b0, rf_we_o);
        check_bit("mem_req_o", 1'b0, mem_req_o);
        check_bit("mem_we_o", 1'b0, mem_we_o);
    endtask

    task automatic check_decoded(input int k, input logic exp_valid);
        check_bit("valid_o", exp_valid, valid_o);
        check_reg_addr("rd_sel_o", golden[k][1][4:0], rd_sel_o);
        check_reg_addr("rs1_sel_o", golden[k][2][4:0], rs1_sel_o);
        check_reg_addr("rs2_sel_o", golden[k][3][4:0], rs2_sel_o);
        check_funct3("mem_access_width_o", golden[k][4][2:0], mem_access_width_o);
        check_word("imm_o", golden[k][5], imm_o);
        check_bit("illegal_instr_o", golden[k][6][0], illegal_instr_o);
        check_bit("jump_en_o", golden[k][7][0], jump_en_o);
        check_bit("wfi_o", golden[k][8][0], wfi_o);
        check_cmp_func("comparison_type_o", cmp_func_e'(golden[k][9][2:0]), comparison_type_o);
        check_bit("rf_we_o", golden[k][10][0], rf_we_o);
        check_din_sel("rf_din_sel_o", rf_din_sel_e'(golden[k][11][2:0]), rf_din_sel_o);
        check_bit("a_op_sel_o", golden[k][12][0], a_op_sel_o);
        check_bit("b_op_sel_o", golden[k][13][0], b_op_sel_o);
        check_bit("cmp_b_op_sel_o", golden[k][14][0], cmp_b_op_sel_o);
        check_alu_op("alu_op_sel_o", alu_op_e'(golden[k][15][3:0]), alu_op_sel_o);
        check_bit("mem_req_o", golden[k][16][0], mem_req_o);
        check_bit("mem_we_o", golden[k][17][0], mem_we_o);
    endtask

    task automatic load_golden();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [0:N_COL-1];
        fd = $fopen("sim/decode_golden.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd) && n_vec < MAX_VEC)
        begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                          f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (cnt == N_COL)  // Comment and blank lines fall through
            begin
                for (int c = 0; c < N_COL; c++)
                    golden[n_vec][c] = f[c];
                n_vec++;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial
    begin
        int idle;
        void'($urandom(23));
        errors        = 0;
        n_vec         = 0;
        loaded        = 1'b0;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        load_golden();
        loaded = 1'b1;
        if (n_vec == 0)
        begin
            $display("No test vectors could be read from the golden file");
            errors++;
        end

        repeat (4) @(posedge clk_i);
        #2 reset_i = 1'b0;
        @(negedge clk_i);
        check_reset_state();
        @(negedge clk_i);
        check_reset_state();  // First cycle out of reset

        for (int k = 0; k < n_vec; k++)
        begin
            @(posedge clk_i);
            #2;
            instr_valid_i = 1'b1;
            instr_i       = golden[k][0];
            @(posedge clk_i);
            #2;
            instr_valid_i = 1'b0;
            instr_i       = $urandom;  // Must not leak through
            @(negedge clk_i);
            check_decoded(k, 1'b1);
            idle = $urandom_range(3, 0);
            repeat (idle)
            begin
                @(posedge clk_i);
                #2 instr_i = $urandom;
                @(negedge clk_i);
                check_decoded(k, 1'b0);  // Outputs hold
            end
        end

        $display("Decode stage run done, %0d vectors, %0d errors", n_vec, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        repeat (n_vec * 5 + 20) @(posedge clk_i);
        $display("Run timed out after %0d cycles without finishing", n_vec * 5 + 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim/decode_golden.txt
# instr rd rs1 rs2 width imm illegal jump wfi cmp rf_we din a_sel b_sel cmp_b_sel alu mem_req mem_we
# all hex; cmp/din/alu use the package encodings
002081B3 03 01 02 0 00208000 0 0 0 0 1 2 0 0 0 0 0 0
407302B3 05 06 07 0 40730000 0 0 0 0 1 2 0 0 0 1 0 0
40A4D433 08 09 0A 5 40A4D000 0 0 0 0 1 2 0 0 0 4 0 0
00D625B3 0B 0C 0D 2 00D62000 0 0 0 3 1 3 0 0 0 0 0 0
003140B3 01 02 03 4 00314000 0 0 0 0 1 2 0 0 0 5 0 0
FFB10093 01 02 1B 0 FFFFFFFB 0 0 0 0 1 2 0 1 0 0 0 0
4032D213 04 05 03 5 00000403 0 0 0 0 1 2 0 1 0 4 0 0
0643B313 06 07 04 3 00000064 0 0 0 5 1 3 0 0 1 0 0 0
0FF47393 07 08 1F 7 000000FF 0 0 0 0 1 2 0 1 0 7 0 0
FFC12283 05 02 1C 2 FFFFFFFC 0 0 0 0 1 4 0 1 0 0 1 0
0081C303 06 03 08 4 00000008 0 0 0 0 1 4 0 1 0 0 1 0
00009083 01 01 00 1 00000000 0 0 0 0 1 4 0 1 0 0 1 0
FE712C23 18 02 07 2 FFFFFFF8 0 0 0 0 0 0 0 1 0 0 1 1
005301A3 03 06 05 0 00000003 0 0 0 0 0 0 0 1 0 0 1 1
FE2088E3 11 01 02 0 FFFFFFF0 0 1 0 1 0 0 1 1 0 0 0 0
00419463 08 03 04 1 00000008 0 1 0 2 0 0 1 1 0 0 0 0
0062C263 04 05 06 4 00000004 0 1 0 3 0 0 1 1 0 0 0 0
0083D863 10 07 08 5 00000010 0 1 0 4 0 0 1 1 0 0 0 0
0020E263 04 01 02 6 00000004 0 1 0 5 0 0 1 1 0 0 0 0
FE20FEE3 1D 01 02 7 FFFFFFFC 0 1 0 6 0 0 1 1 0 0 0 0
001000EF 01 00 01 0 00000800 0 1 0 0 1 1 1 1 0 0 0 0
FFFFF06F 00 1F 1F 7 FFFFFFFE 0 1 0 0 1 1 1 1 0 0 0 0
FF4280E7 01 05 14 0 FFFFFFF4 0 1 0 0 1 1 0 1 0 0 0 0
12345537 0A 08 03 5 12345000 0 0 0 0 1 0 0 0 0 0 0 0
FFFFF117 02 1F 1F 7 FFFFF000 0 0 0 0 1 2 1 1 0 0 0 0
10500073 00 00 05 0 00000105 0 0 1 0 1 2 0 1 0 0 0 0
12345678 0C 08 03 5 12345000 1 0 0 0 0 0 0 0 0 0 0 0
0000B083 01 01 00 3 00000000 1 0 0 0 1 4 0 1 0 0 1 0
00114023 00 02 01 4 00000000 1 0 0 0 0 0 0 1 0 0 1 1
40209033 00 01 02 1 40209000 1 0 0 0 0 0 0 0 0 0 0 0
00000073 00 00 00 0 00000000 1 0 0 0 0 0 0 0 0 0 0 0
00100073 00 00 01 0 00100000 1 0 0 0 0 0 0 0 0 0 0 0
30200073 00 00 02 0 30200000 1 0 0 0 0 0 0 0 0 0 0 0
300110F3 01 02 00 1 30011000 1 0 0 0 0 0 0 0 0 0 0 0
022081B3 03 01 02 0 02208000 1 0 0 0 0 0 0 0 0 0 0 0

// File: filelist.f
source/rv_decode_pkg.sv
source/decode_ctrl_if.sv
source/rv_ctrl_decode.sv
source/rv_imm_gen.sv
source/rv_decode_stage.sv
sim/rv_decode_stage_chk.sv
sim/rv_decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= rv_decode_stage_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
